// File: fixsqrt.f
design/fixsqrt_num_pkg.sv
design/fixsqrt_cmd_pkg.sv
design/op_decode.sv
design/sqrt_iter.sv
design/result_format.sv
design/fixsqrt_top.sv
tests/tb_clock.sv
tests/fixsqrt_tb.sv

// File: Makefile
SRCS := $(wildcard design/*.sv tests/*.sv)

all: run

obj_dir/Vfixsqrt_tb: fixsqrt.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module fixsqrt_tb -f fixsqrt.f

run: obj_dir/Vfixsqrt_tb
	@out="$$(./obj_dir/Vfixsqrt_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx 'All tests passed!'

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: tests/fixsqrt_tb.sv
`timescale 1ns/1ps

module fixsqrt_tb;

    localparam int RESET_CYCLES = 10;
    localparam int N_RAND       = 24;       // Random commands per operation
    localparam int HOLD_LEN     = 8;        // Cycles of start held high
    localparam int RAND_BURST   = 60;       // Cycles of random start pattern
    localparam int NUM_CMDS     = 4 + N_RAND + 4 + N_RAND + 6 + HOLD_LEN + RAND_BURST;
    localparam int WATCHDOG_CYCLES = NUM_CMDS * 40 + RESET_CYCLES;
    localparam int IDLE_LATENCY = fixsqrt_num_pkg::ITER_COUNT + 3;

    typedef struct packed {
        fixsqrt_cmd_pkg::fx_result_t res;   // Model result
        int                          due;   // Cycle of done or -1 when not fixed
    } exp_entry_t;

    logic                        clk;
    logic                        arst_n;
    logic                        start;
    fixsqrt_cmd_pkg::cmd_t       cmd;
    logic                        busy;
    logic                        done;
    fixsqrt_cmd_pkg::fx_result_t result;

    logic       seen_start;     // Set with the first start
    exp_entry_t exp_q[$];       // Accepted commands, oldest first
    int         errors   = 0;
    int         cycle_no = 0;
    int         n_acc    = 0;
    int         n_done   = 0;   // Every done pulse, expected or not

    tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (.clk(clk), .arst_n(arst_n));

    fixsqrt_top uut (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .cmd    (cmd),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    // Root by bitwise search from the top candidate bit down
    function automatic longint unsigned floor_sqrt(input longint unsigned x);
        longint unsigned r;
        longint unsigned cand;
        int              bitpos;
        r = 0;
        for (bitpos = fixsqrt_num_pkg::ROOT_WIDTH - 1; bitpos >= 0; bitpos--) begin
            cand = r | (64'd1 << bitpos);
            if (cand * cand <= x) r = cand;
        end
        return r;
    endfunction

    function automatic fixsqrt_cmd_pkg::fx_result_t expect_result(
        input fixsqrt_cmd_pkg::cmd_t c
    );
        longint                      ca;
        longint                      cb;
        longint unsigned             rad;
        longint unsigned             root;
        longint unsigned             rounded;
        fixsqrt_cmd_pkg::fx_result_t res;
        if (c.op == fixsqrt_cmd_pkg::OP_MAG) begin
            ca  = $signed(c.a[fixsqrt_num_pkg::COMP_WIDTH-1:0]);   // Sign extended Q8.8
            cb  = $signed(c.b[fixsqrt_num_pkg::COMP_WIDTH-1:0]);
            rad = longint'(ca * ca + cb * cb) << fixsqrt_num_pkg::FRAC_IN;
        end else begin
            rad = longint'(c.a) << fixsqrt_num_pkg::FRAC_IN;
        end
        root    = floor_sqrt(rad);
        rounded = (root >> fixsqrt_num_pkg::ROUND_SHIFT)
                + ((root >> (fixsqrt_num_pkg::ROUND_SHIFT - 1)) & 1);   // Half up
        res.exact     = (root * root == rad);
        res.saturated = (rounded > 64'hFFFF);
        res.value     = res.saturated ? 16'hFFFF : rounded[15:0];
        return res;
    endfunction

    function automatic fixsqrt_cmd_pkg::cmd_t make_cmd(
        input fixsqrt_cmd_pkg::op_e op,
        input logic [31:0]          a,
        input logic [31:0]          b
    );
        fixsqrt_cmd_pkg::cmd_t c;
        c.op = op;
        c.a  = a;
        c.b  = b;
        return c;
    endfunction

    // Wait at the falling edge until nothing is pending
    task automatic wait_idle();
        do @(negedge clk); while (busy || exp_q.size() != 0);
    endtask

    task automatic run_cmd(input fixsqrt_cmd_pkg::cmd_t c);
        wait_idle();
        @(posedge clk);
        start      <= 1'b1;
        cmd        <= c;
        seen_start <= 1'b1;
        @(posedge clk);
        start      <= 1'b0;
    endtask

    // Pop on done before push on accept so an empty queue means execute is idle
    always @(posedge clk) begin
        exp_entry_t entry;
        if (arst_n) begin
            if (done) begin
                n_done++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%0t: done pulsed with no accepted command pending", $time);
                end else begin
                    entry = exp_q.pop_front();
                    assert (result.value == entry.res.value) else begin
                        errors++;
                        $display("FAIL %0t result.value expected %h actual %h",
                                 $time, entry.res.value, result.value);
                    end
                    assert (result.exact == entry.res.exact) else begin
                        errors++;
                        $display("FAIL %0t result.exact expected %b actual %b",
                                 $time, entry.res.exact, result.exact);
                    end
                    assert (result.saturated == entry.res.saturated) else begin
                        errors++;
                        $display("FAIL %0t result.saturated expected %b actual %b",
                                 $time, entry.res.saturated, result.saturated);
                    end
                    if (entry.due >= 0) begin
                        assert (cycle_no == entry.due) else begin
                            errors++;
                            $display("FAIL %0t done cycle expected %0d actual %0d",
                                     $time, entry.due, cycle_no);
                        end
                    end
                end
            end
            if (start && !busy) begin   // Accepted start
                entry.res = expect_result(cmd);
                entry.due = (exp_q.size() == 0) ? cycle_no + IDLE_LATENCY : -1;
                exp_q.push_back(entry);
                n_acc++;
            end
        end
        cycle_no++;
    end

    a_quiet_busy : assert property (
        @(posedge clk) disable iff (!arst_n) !seen_start |-> !busy
    ) else begin
        errors++;
        $display("FAIL %0t busy expected 0 actual %b", $time, $sampled(busy));
    end

    a_quiet_done : assert property (
        @(posedge clk) disable iff (!arst_n) !seen_start |-> !done
    ) else begin
        errors++;
        $display("FAIL %0t done expected 0 actual %b", $time, $sampled(done));
    end

    a_done_one_cycle : assert property (
        @(posedge clk) disable iff (!arst_n) done |=> !done
    ) else begin
        errors++;
        $display("FAIL %0t done expected 0 actual 1 in the cycle after done", $time);
    end

    // Saturation only ever comes with an all ones value
    a_sat_all_ones : assert property (
        @(posedge clk) disable iff (!arst_n) done && result.saturated |-> &result.value
    ) else begin
        errors++;
        $display("FAIL %0t result.value expected ffff actual %h", $time,
                 $sampled(result.value));
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout after %0d cycles, %0d commands still pending, %0d errors",
                 WATCHDOG_CYCLES, exp_q.size(), errors);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(79));
        start      = 1'b0;
        cmd        = '0;
        seen_start = 1'b0;
        @(posedge arst_n);
        repeat (5) @(posedge clk);      // Quiet stretch before any start

        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'h0004_0000, '0));   // 4.0
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'h0002_4000, '0));   // 2.25
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'h0000_0000, '0));
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'h0001_0000, '0));   // 1.0
        repeat (N_RAND) run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, $urandom(), $urandom()));

        // Vectors with junk in the upper halves of a and b
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_MAG, 32'h1234_FD00, 32'hABCD_0400));  // (-3, 4)
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_MAG, 32'h0000_0000, 32'hFFFF_0000));  // Zero
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_MAG, 32'h0000_8000, 32'h0000_8000));  // Largest
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_MAG, 32'h0000_FFFF, 32'h0000_0001));
        repeat (N_RAND) run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_MAG, $urandom(), $urandom()));

        // Top of the operand range and its neighbors
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'hFFFF_FFFF, '0));
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'hFFFF_FFFE, '0));
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'hFFFF_8000, '0));
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'hFFFF_0000, '0));
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'hFFFE_FFFF, '0));
        run_cmd(make_cmd(fixsqrt_cmd_pkg::OP_SQRT, 32'hFFFF_7FFF, '0));

        // Start held high so most edges land while busy
        wait_idle();
        repeat (HOLD_LEN) begin
            @(posedge clk);
            start <= 1'b1;
            cmd   <= make_cmd(fixsqrt_cmd_pkg::op_e'($urandom_range(1)), $urandom(), $urandom());
        end
        @(posedge clk);
        start <= 1'b0;

        // Sparse random starts with some while a command waits in decode
        repeat (RAND_BURST) begin
            @(posedge clk);
            start <= ($urandom_range(3) == 0);
            cmd   <= make_cmd(fixsqrt_cmd_pkg::op_e'($urandom_range(1)), $urandom(), $urandom());
        end
        @(posedge clk);
        start <= 1'b0;

        wait_idle();
        repeat (40) @(posedge clk);     // Any late done shows up as unexpected

        if (n_acc != n_done) begin
            errors++;
            $display("%0d accepted commands but %0d results", n_acc, n_done);
        end
        $display("Accepted %0d, results %0d, errors %0d", n_acc, n_done, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;             // Released on a rising edge
    end

endmodule

// File: design/fixsqrt_top.sv
`timescale 1ns/1ps

module fixsqrt_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  fixsqrt_cmd_pkg::cmd_t       cmd,
    output logic                        busy,
    output logic                        done,
    output fixsqrt_cmd_pkg::fx_result_t result
);

    logic                       dec_valid;  // Decode slot holds a radicand
    fixsqrt_cmd_pkg::rad_req_t  dec_req;
    logic                       exec_load;  // Execute takes the slot
    logic                       root_valid;
    fixsqrt_cmd_pkg::root_res_t root_res;

    // Command slot and radicand forming
    op_decode u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .cmd       (cmd),
        .exec_load (exec_load),
        .busy      (busy),
        .dec_valid (dec_valid),
        .dec_req   (dec_req)
    );

    // Bit-serial root, ITER_COUNT+1 cycles per command
    sqrt_iter u_exec (
        .clk        (clk),
        .arst_n     (arst_n),
        .dec_valid  (dec_valid),
        .dec_req    (dec_req),
        .exec_load  (exec_load),
        .root_valid (root_valid),
        .root_res   (root_res)
    );

    result_format u_result (
        .clk        (clk),
        .arst_n     (arst_n),
        .root_valid (root_valid),
        .root_res   (root_res),
        .done       (done),
        .result     (result)
    );

endmodule

// File: design/result_format.sv
`timescale 1ns/1ps

module result_format (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        root_valid,
    input  fixsqrt_cmd_pkg::root_res_t  root_res,
    output logic                        done,
    output fixsqrt_cmd_pkg::fx_result_t result
);

    // One extra bit to catch the carry out of rounding
    logic [fixsqrt_num_pkg::OUT_WIDTH:0] rounded;
    logic                               sat;
    fixsqrt_num_pkg::out_t              value;

    // Q8.16 to Q8.8, round half up on the highest dropped bit
    assign rounded = {1'b0, root_res.root[fixsqrt_num_pkg::ROOT_WIDTH-1:
                                          fixsqrt_num_pkg::ROUND_SHIFT]}
                   + root_res.root[fixsqrt_num_pkg::ROUND_SHIFT-1];

    assign sat   = rounded[fixsqrt_num_pkg::OUT_WIDTH];          // Past the largest out_t
    assign value = sat ? '1 : rounded[fixsqrt_num_pkg::OUT_WIDTH-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else begin
            done <= root_valid;
        end
    end

    // Held until the next root arrives
    always_ff @(posedge clk) begin
        if (root_valid) begin
            result.value     <= value;
            result.exact     <= root_res.exact;
            result.saturated <= sat;
        end
    end

    // Upstream root_valid must stay a single pulse
    a_done_pulse : assert property (
        @(posedge clk) disable iff (!arst_n) done |=> !done
    );

endmodule

// File: design/sqrt_iter.sv
`timescale 1ns/1ps

module sqrt_iter (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       dec_valid,
    input  fixsqrt_cmd_pkg::rad_req_t  dec_req,
    output logic                       exec_load,
    output logic                       root_valid,
    output fixsqrt_cmd_pkg::root_res_t root_res
);

    fixsqrt_cmd_pkg::exec_state_e          state_q;
    fixsqrt_cmd_pkg::exec_state_e          state_d;
    logic [fixsqrt_num_pkg::CNT_WIDTH-1:0] cnt_q;    // Root bits left after this one

    fixsqrt_num_pkg::rad_t  rad_q;      // Unconsumed radicand, next pair at the top
    fixsqrt_num_pkg::rem_t  rem_q;      // Partial remainder
    fixsqrt_num_pkg::root_t root_q;     // Partial root, grows from the LSB

    // Two guard bits over the remainder for the shifted value and the trial
    logic [$bits(fixsqrt_num_pkg::rem_t)+1:0] rem_shift;
    logic [$bits(fixsqrt_num_pkg::rem_t)+1:0] trial;
    logic [$bits(fixsqrt_num_pkg::rem_t)+1:0] rem_diff;
    logic                                     fits;      // Trial divisor fits, root bit is 1

    // Bring down the next two radicand bits
    assign rem_shift = {rem_q, rad_q[fixsqrt_num_pkg::RAD_WIDTH-1 -: 2]};
    assign trial     = {1'b0, root_q, 2'b01};   // root*4 + 1
    assign rem_diff  = rem_shift - trial;
    assign fits      = (rem_shift >= trial);

    assign exec_load  = (state_q == fixsqrt_cmd_pkg::IDLE) && dec_valid;
    assign root_valid = (state_q == fixsqrt_cmd_pkg::DONE);   // Single DONE cycle

    assign root_res.root  = root_q;
    assign root_res.exact = (rem_q == '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            fixsqrt_cmd_pkg::IDLE: begin
                if (dec_valid) state_d = fixsqrt_cmd_pkg::RUN;
            end
            fixsqrt_cmd_pkg::RUN: begin
                if (cnt_q == '0) state_d = fixsqrt_cmd_pkg::DONE; // Last root bit
            end
            fixsqrt_cmd_pkg::DONE: state_d = fixsqrt_cmd_pkg::IDLE;
            default:               state_d = fixsqrt_cmd_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= fixsqrt_cmd_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (exec_load) begin
                cnt_q <= fixsqrt_num_pkg::CNT_WIDTH'(fixsqrt_num_pkg::ITER_COUNT - 1);
            end else if (state_q == fixsqrt_cmd_pkg::RUN && cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Datapath, one root bit per RUN cycle
    always_ff @(posedge clk) begin
        if (exec_load) begin
            rad_q  <= dec_req.rad;
            rem_q  <= '0;
            root_q <= '0;
        end else if (state_q == fixsqrt_cmd_pkg::RUN) begin
            rad_q  <= rad_q << 2;
            rem_q  <= fits ? fixsqrt_num_pkg::rem_t'(rem_diff)     // Restore skipped on fit
                           : fixsqrt_num_pkg::rem_t'(rem_shift);
            root_q <= {root_q[fixsqrt_num_pkg::ROOT_WIDTH-2:0], fits};
        end
    end

    a_root_valid_pulse : assert property (
        @(posedge clk) disable iff (!arst_n) root_valid |=> !root_valid
    );

    // Counter strictly falls each RUN cycle until DONE takes over
    a_cnt_no_wrap : assert property (
        @(posedge clk) disable iff (!arst_n)
        state_q == fixsqrt_cmd_pkg::RUN |=>
            (state_q == fixsqrt_cmd_pkg::DONE) || (cnt_q < $past(cnt_q))
    );

endmodule

// File: design/op_decode.sv
`timescale 1ns/1ps

module op_decode (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    input  fixsqrt_cmd_pkg::cmd_t     cmd,
    input  logic                      exec_load,
    output logic                      busy,
    output logic                      dec_valid,
    output fixsqrt_cmd_pkg::rad_req_t dec_req
);

    logic                   slot_full;  // One pending command
    logic                   accept;
    fixsqrt_num_pkg::comp_t comp_a;
    fixsqrt_num_pkg::comp_t comp_b;
    fixsqrt_num_pkg::opnd_t sq_a;       // Q16.16 square, never negative
    fixsqrt_num_pkg::opnd_t sq_b;
    fixsqrt_num_pkg::opnd_t q16_val;    // Q16.16 value to take the root of

    assign accept = start && !slot_full;   // Start dropped while busy

    // Signed components from the low halves of both operands
    assign comp_a = fixsqrt_num_pkg::comp_t'(cmd.a[fixsqrt_num_pkg::COMP_WIDTH-1:0]);
    assign comp_b = fixsqrt_num_pkg::comp_t'(cmd.b[fixsqrt_num_pkg::COMP_WIDTH-1:0]);

    // Signed multiply at full width, Q8.8 * Q8.8 gives Q16.16
    assign sq_a = comp_a * comp_a;
    assign sq_b = comp_b * comp_b;

    // Sum of two squares tops out at 2^31 and fits unsigned
    assign q16_val = (cmd.op == fixsqrt_cmd_pkg::OP_MAG) ? sq_a + sq_b : cmd.a;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_full <= 1'b0;
        end else if (exec_load) begin
            slot_full <= 1'b0;      // Execute took it
        end else if (accept) begin
            slot_full <= 1'b1;
        end
    end

    // Radicand registered with the slot, pad FRAC_IN zeros at the bottom
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_req.rad <= {q16_val, {fixsqrt_num_pkg::FRAC_IN{1'b0}}};
        end
    end

    assign busy      = slot_full;
    assign dec_valid = slot_full;

    // Execute must only pull from a filled slot
    a_load_needs_slot : assert property (
        @(posedge clk) disable iff (!arst_n) exec_load |-> slot_full
    );

endmodule

// File: design/fixsqrt_cmd_pkg.sv
package fixsqrt_cmd_pkg;

    // Operation select
    typedef enum logic [0:0] {
        OP_SQRT = 1'b0,     // sqrt of operand a, unsigned Q16.16
        OP_MAG  = 1'b1      // |(a, b)| with Q8.8 components in the low halves
    } op_e;

    // Command as presented with start
    typedef struct packed {
        op_e                    op;
        fixsqrt_num_pkg::opnd_t a;
        fixsqrt_num_pkg::opnd_t b;     // Only read for OP_MAG
    } cmd_t;

    // Decode to execute
    typedef struct packed {
        fixsqrt_num_pkg::rad_t rad;    // Padded radicand
    } rad_req_t;

    // Execute to result
    typedef struct packed {
        fixsqrt_num_pkg::root_t root;  // Q8.16 floor root
        logic                   exact; // Remainder was zero
    } root_res_t;

    // Unit output
    typedef struct packed {
        fixsqrt_num_pkg::out_t value;  // Q8.8 rounded root
        logic                  exact;
        logic                  saturated;
    } fx_result_t;

    typedef enum logic [1:0] {IDLE, RUN, DONE} exec_state_e;

endpackage

// File: design/fixsqrt_num_pkg.sv
package fixsqrt_num_pkg;

    // Operand side
    localparam int OPND_WIDTH  = 32;            // Q16.16 operand word
    localparam int FRAC_IN     = 16;            // Fraction bits of the operand
    localparam int COMP_WIDTH  = 16;            // One signed Q8.8 vector component

    // Radicand is the operand with FRAC_IN zeros appended below it
    localparam int RAD_WIDTH   = OPND_WIDTH + FRAC_IN;

    // Root of the padded radicand is Q8.16
    localparam int ROOT_WIDTH  = RAD_WIDTH / 2;

    // Result side
    localparam int OUT_WIDTH   = 16;            // Q8.8 result
    localparam int ROUND_SHIFT = ROOT_WIDTH - OUT_WIDTH; // Fraction bits dropped by rounding

    // One root bit per execute cycle
    localparam int ITER_COUNT  = ROOT_WIDTH;
    localparam int CNT_WIDTH   = 5;             // Holds ITER_COUNT-1

    typedef logic        [OPND_WIDTH-1:0] opnd_t;
    typedef logic signed [COMP_WIDTH-1:0] comp_t;   // Two's complement Q8.8
    typedef logic        [RAD_WIDTH-1:0]  rad_t;
    typedef logic        [ROOT_WIDTH-1:0] root_t;

    // Remainder never exceeds twice the partial root
    typedef logic        [ROOT_WIDTH:0]   rem_t;

    typedef logic        [OUT_WIDTH-1:0]  out_t;

endpackage
